// ==== common/adc_rx_consts.svh ====
// adc receive datapath constants
// lane, byte, sample and beat sizes shared by the package and the rtl

`ifndef ADC_RX_CONSTS_SVH
`define ADC_RX_CONSTS_SVH

// ************************************************************
// link side
// ************************************************************

// deframed link data per rx_clk cycle
`define ADC_LANE_W 128
// one octet of lane data
`define ADC_BYTE_W 8
// byte distance from the high byte lane to the low byte lane of a pair
`define ADC_LANE_PAIR_OFS 4
// first byte of channel b within a beat
`define ADC_CHAN_B_OFS 8

// ************************************************************
// sample side
// ************************************************************

`define ADC_NUM_CHAN 2
`define ADC_SAMPLE_W 16
`define ADC_SAMPLES_PER_BEAT 4
// one channel worth of samples per beat
`define ADC_BEAT_W (`ADC_SAMPLE_W * `ADC_SAMPLES_PER_BEAT)
// packed output word
`define ADC_OUT_W 128

`endif

// ==== common/adc_rx_pkg.sv ====
// adc receive datapath types
// sample, beat and word vectors plus the packer state encoding

`include "adc_rx_consts.svh"

package adc_rx_pkg;

  // ************************************************************
  // data vectors
  // ************************************************************

  // one adc sample, offset binary or two's complement by stage
  typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

  // four samples of one channel, sample 0 in the low bits
  typedef logic [`ADC_BEAT_W-1:0] chan_beat_t;

  // deframed lane data, one rx_clk cycle
  typedef logic [`ADC_LANE_W-1:0] lane_word_t;

  // packed output word
  typedef logic [`ADC_OUT_W-1:0] out_word_t;

  // per-channel enable, bit 0 is channel a
  typedef logic [`ADC_NUM_CHAN-1:0] chan_en_t;

  // ************************************************************
  // packer control
  // ************************************************************

  // pack_empty  nothing held
  // pack_half   one single-channel beat waiting for its partner
  typedef enum logic {
    pack_empty = 1'b0,
    pack_half  = 1'b1
  } pack_state_t;

endpackage

// ==== hdl/adc_rx_if.sv ====
// adc receive input side
// splits each deframed link beat into channel a and channel b samples,
// registers them with the valid strobe and reports link status

`timescale 1ns/10ps

`include "adc_rx_consts.svh"

module adc_rx_if (
  input  logic                   rx_clk,
  input  logic                   adc_rst,
  input  adc_rx_pkg::lane_word_t rx_data,
  input  logic                   rx_valid,
  output adc_rx_pkg::chan_beat_t beat_a,
  output adc_rx_pkg::chan_beat_t beat_b,
  output logic                   beat_valid,
  output logic                   link_status
);

  import adc_rx_pkg::*;

  localparam int SW = `ADC_SAMPLE_W;
  localparam int BW = `ADC_BYTE_W;

  // unpacked samples before the register stage
  chan_beat_t unpack_a;
  chan_beat_t unpack_b;

  // ************************************************************
  // byte unpack
  // ************************************************************

  // high byte comes from the first lane of the pair,
  // low byte from the second lane four bytes up
  always_comb begin
    for (int k = 0; k < `ADC_SAMPLES_PER_BEAT; k++) begin
      unpack_a[k*SW +: SW] = {rx_data[k*BW +: BW],
                              rx_data[(k+`ADC_LANE_PAIR_OFS)*BW +: BW]};
      // channel b sits in the upper half of the beat
      unpack_b[k*SW +: SW] = {rx_data[(k+`ADC_CHAN_B_OFS)*BW +: BW],
                              rx_data[(k+`ADC_CHAN_B_OFS+`ADC_LANE_PAIR_OFS)*BW +: BW]};
    end
  end

  // ************************************************************
  // output registers
  // ************************************************************

  // sample payload, only meaningful with beat_valid
  always_ff @(posedge rx_clk) begin
    beat_a <= unpack_a;
    beat_b <= unpack_b;
  end

  // strobe follows rx_valid by one cycle
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= rx_valid;
    end
  end

  // link is up from the first cycle out of reset
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      link_status <= 1'b0;
    end else begin
      link_status <= 1'b1;
    end
  end

endmodule

// ==== adc_channel/adc_channel.sv ====
// adc channel processing
// two stage pipe per channel: optional offset binary to two's complement
// conversion, then signed calibration offset with saturation and an
// over-range flag per beat

`timescale 1ns/10ps

`include "adc_rx_consts.svh"

module adc_channel (
  input  logic                   rx_clk,
  input  logic                   adc_rst,
  input  adc_rx_pkg::chan_beat_t beat,
  input  logic                   beat_valid,
  input  logic                   offset_binary,
  input  adc_rx_pkg::sample_t    offset,
  output adc_rx_pkg::chan_beat_t proc_beat,
  output logic                   proc_valid,
  output logic                   proc_or
);

  import adc_rx_pkg::*;

  localparam int SW = `ADC_SAMPLE_W;
  localparam int NS = `ADC_SAMPLES_PER_BEAT;

  // stage 1 signals
  chan_beat_t fmt_mask;
  chan_beat_t fmt_beat;
  logic       fmt_valid;

  // stage 2 signals, one extra bit for the sum
  logic signed [SW:0] sum_s [NS];
  chan_beat_t         sat_beat;
  logic [NS-1:0]      sat_hit;

  // ************************************************************
  // stage 1 format conversion
  // ************************************************************

  // flipping the msb maps offset binary onto two's complement
  always_comb begin
    fmt_mask = '0;
    for (int k = 0; k < NS; k++) begin
      fmt_mask[k*SW+SW-1] = offset_binary;
    end
  end

  always_ff @(posedge rx_clk) begin
    fmt_beat <= beat ^ fmt_mask;
  end

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= beat_valid;
    end
  end

  // ************************************************************
  // stage 2 offset and saturation
  // ************************************************************

  always_comb begin
    for (int k = 0; k < NS; k++) begin
      // both operands sign extended to 17 bits, the sum cannot wrap
      sum_s[k] = $signed({fmt_beat[k*SW+SW-1], fmt_beat[k*SW +: SW]})
               + $signed({offset[SW-1], offset});
      // top two bits disagree when the result left the 16 bit range
      sat_hit[k] = sum_s[k][SW] ^ sum_s[k][SW-1];
      if (!sat_hit[k]) begin
        sat_beat[k*SW +: SW] = sum_s[k][SW-1:0];
      end else if (sum_s[k][SW]) begin
        // below the range, clamp to most negative
        sat_beat[k*SW +: SW] = {1'b1, {(SW-1){1'b0}}};
      end else begin
        // above the range, clamp to most positive
        sat_beat[k*SW +: SW] = {1'b0, {(SW-1){1'b1}}};
      end
    end
  end

  // processed samples, payload only
  always_ff @(posedge rx_clk) begin
    proc_beat <= sat_beat;
  end

  // flag is qualified by the strobe so it never shows on idle cycles
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      proc_valid <= 1'b0;
      proc_or    <= 1'b0;
    end else begin
      proc_valid <= fmt_valid;
      proc_or    <= fmt_valid & (|sat_hit);
    end
  end

endmodule

// ==== adc_pack/adc_pack.sv ====
// adc output packer
// builds 128 bit output words from the processed channel beats:
// interleaved a/b samples with both channels on, two consecutive beats
// of one channel with a single channel on

`timescale 1ns/10ps

`include "adc_rx_consts.svh"

module adc_pack (
  input  logic                   rx_clk,
  input  logic                   adc_rst,
  input  adc_rx_pkg::chan_beat_t beat_a,
  input  adc_rx_pkg::chan_beat_t beat_b,
  input  logic                   or_a,
  input  logic                   or_b,
  input  logic                   beat_valid,
  input  adc_rx_pkg::chan_en_t   chan_enable,
  output adc_rx_pkg::out_word_t  out_data,
  output logic                   out_valid,
  output logic                   out_or_a,
  output logic                   out_or_b
);

  import adc_rx_pkg::*;

  localparam int SW = `ADC_SAMPLE_W;
  localparam int NS = `ADC_SAMPLES_PER_BEAT;

  // control state
  pack_state_t state;
  pack_state_t state_next;
  chan_en_t    en_q;
  logic        en_change;

  // held first beat in single channel mode
  chan_beat_t  hold_beat;
  logic        hold_or;
  logic        hold_load;

  // selected channel in single channel mode
  chan_beat_t  sel_beat;
  logic        sel_or;

  // next output word
  out_word_t   word_next;
  logic        word_done;
  logic        or_a_next;
  logic        or_b_next;

  // a0 b0 a1 b1 a2 b2 a3 b3 from the low bits up
  function automatic out_word_t interleave(chan_beat_t a, chan_beat_t b);
    out_word_t w;
    for (int k = 0; k < NS; k++) begin
      w[(2*k)*SW +: SW]   = a[k*SW +: SW];
      w[(2*k+1)*SW +: SW] = b[k*SW +: SW];
    end
    return w;
  endfunction

  // any edit of the enables drops a half built word
  assign en_change = (chan_enable != en_q);

  // with only one channel on, pick that one
  assign sel_beat = chan_enable[0] ? beat_a : beat_b;
  assign sel_or   = chan_enable[0] ? or_a : or_b;

  // ************************************************************
  // next state and word
  // ************************************************************

  always_comb begin
    state_next = state;
    word_done  = 1'b0;
    hold_load  = 1'b0;
    word_next  = interleave(beat_a, beat_b);
    or_a_next  = 1'b0;
    or_b_next  = 1'b0;
    if (en_change) begin
      state_next = pack_empty;
    end else if (beat_valid) begin
      case (chan_enable)
        2'b11: begin
          // every beat completes a word
          word_done = 1'b1;
          or_a_next = or_a;
          or_b_next = or_b;
        end
        2'b01, 2'b10: begin
          if (state == pack_half) begin
            // second beat goes in the high half
            word_done  = 1'b1;
            word_next  = {sel_beat, hold_beat};
            or_a_next  = chan_enable[0] & (hold_or | sel_or);
            or_b_next  = chan_enable[1] & (hold_or | sel_or);
            state_next = pack_empty;
          end else begin
            hold_load  = 1'b1;
            state_next = pack_half;
          end
        end
        default: begin
          // both channels off, beats are dropped
          state_next = pack_empty;
        end
      endcase
    end
  end

  // ************************************************************
  // registers
  // ************************************************************

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      state     <= pack_empty;
      en_q      <= '0;
      out_valid <= 1'b0;
      out_or_a  <= 1'b0;
      out_or_b  <= 1'b0;
    end else begin
      state     <= state_next;
      en_q      <= chan_enable;
      out_valid <= word_done;
      // flags only show alongside a word
      out_or_a  <= or_a_next;
      out_or_b  <= or_b_next;
    end
  end

  // payload, held between words
  always_ff @(posedge rx_clk) begin
    if (hold_load) begin
      hold_beat <= sel_beat;
      hold_or   <= sel_or;
    end
    if (word_done) begin
      out_data <= word_next;
    end
  end

endmodule

// ==== hdl/adc_rx_top.sv ====
// adc receive datapath top level
// input side, one processing pipe per channel and the output packer,
// configuration ports go straight through to the blocks

`timescale 1ns/10ps

module adc_rx_top (
  input  logic                   rx_clk,
  input  logic                   adc_rst,
  input  adc_rx_pkg::lane_word_t rx_data,
  input  logic                   rx_valid,
  input  adc_rx_pkg::chan_en_t   chan_enable,
  input  logic                   offset_binary,
  input  adc_rx_pkg::sample_t    offset_a,
  input  adc_rx_pkg::sample_t    offset_b,
  output adc_rx_pkg::out_word_t  out_data,
  output logic                   out_valid,
  output logic                   out_or_a,
  output logic                   out_or_b,
  output logic                   link_status
);

  import adc_rx_pkg::*;

  // unpacked beats
  chan_beat_t beat_a;
  chan_beat_t beat_b;
  logic       beat_valid;

  // processed beats
  chan_beat_t proc_a;
  chan_beat_t proc_b;
  logic       proc_valid_a;
  logic       proc_or_a;
  logic       proc_or_b;

  adc_rx_if i_if (
    .rx_clk      (rx_clk),
    .adc_rst     (adc_rst),
    .rx_data     (rx_data),
    .rx_valid    (rx_valid),
    .beat_a      (beat_a),
    .beat_b      (beat_b),
    .beat_valid  (beat_valid),
    .link_status (link_status)
  );

  adc_channel i_chan_a (
    .rx_clk        (rx_clk),
    .adc_rst       (adc_rst),
    .beat          (beat_a),
    .beat_valid    (beat_valid),
    .offset_binary (offset_binary),
    .offset        (offset_a),
    .proc_beat     (proc_a),
    .proc_valid    (proc_valid_a),
    .proc_or       (proc_or_a)
  );

  // both pipes run in lockstep, the packer follows channel a's strobe
  adc_channel i_chan_b (
    .rx_clk        (rx_clk),
    .adc_rst       (adc_rst),
    .beat          (beat_b),
    .beat_valid    (beat_valid),
    .offset_binary (offset_binary),
    .offset        (offset_b),
    .proc_beat     (proc_b),
    .proc_valid    (),
    .proc_or       (proc_or_b)
  );

  adc_pack i_pack (
    .rx_clk      (rx_clk),
    .adc_rst     (adc_rst),
    .beat_a      (proc_a),
    .beat_b      (proc_b),
    .or_a        (proc_or_a),
    .or_b        (proc_or_b),
    .beat_valid  (proc_valid_a),
    .chan_enable (chan_enable),
    .out_data    (out_data),
    .out_valid   (out_valid),
    .out_or_a    (out_or_a),
    .out_or_b    (out_or_b)
  );

endmodule

// ==== verification/adc_rx_tb.sv ====
// adc receive datapath testbench
// replays configuration, stimulus and expected words from the input data file,
// checks each output word, its flags and its latency, and the link status

`timescale 1ns/10ps

module adc_rx_tb;

  import adc_rx_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int RST_CYCLES   = 10;
  localparam int LATENCY      = 4;
  localparam int DRAIN_CYCLES = 8;

  // dut ports
  logic       rx_clk;
  logic       adc_rst;
  lane_word_t rx_data;
  logic       rx_valid;
  chan_en_t   chan_enable;
  logic       offset_binary;
  sample_t    offset_a;
  sample_t    offset_b;
  out_word_t  out_data;
  logic       out_valid;
  logic       out_or_a;
  logic       out_or_b;
  logic       link_status;

  // data file rows with f0 as the wide field
  byte        row_type [$];
  lane_word_t row_f0 [$];
  sample_t    row_f1 [$];
  sample_t    row_f2 [$];
  sample_t    row_f3 [$];

  // expected words in arrival order
  out_word_t  exp_word [$];
  logic       exp_or_a [$];
  logic       exp_or_b [$];
  // cycle of each accepted rx_valid for the latency check
  int         valid_cyc [$];

  int         cyc = 0;
  int         limit = 0;
  int         n_checks = 0;
  int         n_errs = 0;
  int         n_tests = 0;
  int         chk0;
  int         err0;
  logic       test_open = 1'b0;
  string      cur_label;

  adc_rx_top uut (
    .rx_clk        (rx_clk),
    .adc_rst       (adc_rst),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .chan_enable   (chan_enable),
    .offset_binary (offset_binary),
    .offset_a      (offset_a),
    .offset_b      (offset_b),
    .out_data      (out_data),
    .out_valid     (out_valid),
    .out_or_a      (out_or_a),
    .out_or_b      (out_or_b),
    .link_status   (link_status)
  );

  // ************************************************************
  // compare and report
  // ************************************************************

  task automatic check_word(string name, out_word_t exp, out_word_t act);
    n_checks++;
    if (act !== exp) begin
      n_errs++;
      $display("ERR %s exp 0x%032h got 0x%032h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      n_errs++;
      $display("ERR %s exp 0x%h got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_status(logic exp);
    n_checks++;
    if (link_status !== exp) begin
      n_errs++;
      $display("ERR link_status exp 0x%h got 0x%h", exp, link_status);
    end
  endtask

  task automatic report_problem(string msg);
    n_errs++;
    $display("cycle %0d: %s", cyc, msg);
  endtask

  task automatic open_test(string label);
    cur_label = label;
    chk0 = n_checks;
    err0 = n_errs;
    test_open = 1'b1;
  endtask

  task automatic close_test();
    if (test_open) begin
      n_tests++;
      $display("test %0d (%s): %0d checks, %0d errors, %s", n_tests, cur_label,
               n_checks - chk0, n_errs - err0, (n_errs == err0) ? "ok" : "FAILED");
      test_open = 1'b0;
    end
  endtask

  // single channel words complete on every second beat
  task automatic check_latency();
    int n;
    int src;
    n = (chan_enable == 2'b11) ? 1 : 2;
    if (valid_cyc.size() < n) begin
      report_problem("out_valid without enough input beats behind it");
    end else begin
      repeat (n) begin
        src = valid_cyc.pop_front();
      end
      n_checks++;
      if (cyc - src != LATENCY) begin
        report_problem($sformatf("word came %0d cycles after rx_valid", cyc - src));
      end
    end
  endtask

  // ************************************************************
  // data file
  // ************************************************************

  task automatic read_vectors();
    int                 fd;
    int                 code;
    int                 want;
    int                 idle_total;
    byte                typ;
    logic [8*8-1:0]     tok;
    logic [8*256-1:0]   line_buf;
    lane_word_t         f0;
    sample_t            f1;
    sample_t            f2;
    sample_t            f3;
    idle_total = 0;
    fd = $fopen("verification/adc_rx_input.dat", "r");
    if (fd == 0) begin
      report_problem("cannot open verification/adc_rx_input.dat");
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        typ = tok[7:0];
        f0 = '0;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        case (typ)
          "c": begin
            want = 4;
            code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
          end
          "d": begin
            want = 2;
            code = $fscanf(fd, "%h %h", f0, f1);
          end
          "e": begin
            want = 3;
            code = $fscanf(fd, "%h %h %h", f0, f1, f2);
          end
          "w": begin
            want = 1;
            code = $fscanf(fd, "%h", f1);
          end
          default: begin
            want = 0;
            code = $fgets(line_buf, fd);
          end
        endcase
        // comment lines start with # and any other unknown type is a file error
        if (typ == "c" || typ == "d" || typ == "e" || typ == "w") begin
          if (code != want) begin
            report_problem("incomplete row in the stimulus file");
          end
          row_type.push_back(typ);
          row_f0.push_back(f0);
          row_f1.push_back(f1);
          row_f2.push_back(f2);
          row_f3.push_back(f3);
          if (typ == "w") begin
            idle_total += f1;
          end
        end else if (typ != "#") begin
          report_problem("unknown row type in the stimulus file");
        end
      end
      $fclose(fd);
    end
    limit = row_type.size() * 4 + idle_total + 100;
  endtask

  // ************************************************************
  // stimulus
  // ************************************************************

  task automatic drive_beat(lane_word_t data, logic v);
    @(posedge rx_clk);
    #2;
    rx_data = data;
    rx_valid = v;
    if (v && chan_enable != 2'b00) begin
      valid_cyc.push_back(cyc);
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      @(posedge rx_clk);
      #2;
      rx_valid = 1'b0;
    end
  endtask

  // lets every word in flight come out before the next change
  task automatic drain_pipe();
    idle_cycles(DRAIN_CYCLES);
    if (exp_word.size() != 0) begin
      report_problem($sformatf("%0d expected words never appeared", exp_word.size()));
      exp_word.delete();
      exp_or_a.delete();
      exp_or_b.delete();
    end
  endtask

  task automatic apply_config(int i);
    drain_pipe();
    close_test();
    @(posedge rx_clk);
    #2;
    chan_enable = row_f0[i][1:0];
    offset_binary = row_f1[i][0];
    offset_a = row_f2[i];
    offset_b = row_f3[i];
    // a half held beat is dropped by the packer on this change
    valid_cyc.delete();
    open_test($sformatf("chan_enable %b offset_binary %0d offsets %h %h",
                        chan_enable, offset_binary, offset_a, offset_b));
  endtask

  // ************************************************************
  // clock, cycle count, timeout and output monitor
  // ************************************************************

  initial begin
    rx_clk = 1'b0;
    forever begin
      #CLK_HALF rx_clk = ~rx_clk;
    end
  end

  always @(posedge rx_clk) begin
    cyc = cyc + 1;
  end

  initial begin
    wait (limit > 0 && cyc > limit);
    $display("timeout: run did not end within %0d cycles", limit);
    $display("Regression failed");
    $finish;
  end

  // outputs are stable at the falling edge
  always @(negedge rx_clk) begin
    if (!adc_rst && out_valid) begin
      if (exp_word.size() == 0) begin
        report_problem("unexpected out_valid with no word pending");
      end else begin
        check_word("out_data", exp_word.pop_front(), out_data);
        check_flag("out_or_a", exp_or_a.pop_front(), out_or_a);
        check_flag("out_or_b", exp_or_b.pop_front(), out_or_b);
      end
      check_latency();
    end
  end

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    adc_rst = 1'b1;
    rx_data = '0;
    rx_valid = 1'b0;
    chan_enable = 2'b00;
    offset_binary = 1'b0;
    offset_a = '0;
    offset_b = '0;
    read_vectors();

    // link comes up one cycle after reset falls
    open_test("link status and reset");
    repeat (RST_CYCLES) @(posedge rx_clk);
    #2;
    adc_rst = 1'b0;
    @(negedge rx_clk);
    check_status(1'b0);
    @(negedge rx_clk);
    check_status(1'b1);
    close_test();

    foreach (row_type[i]) begin
      case (row_type[i])
        "c": apply_config(i);
        "d": drive_beat(row_f0[i], row_f1[i][0]);
        "w": idle_cycles(row_f1[i]);
        default: begin
          exp_word.push_back(row_f0[i]);
          exp_or_a.push_back(row_f1[i][0]);
          exp_or_b.push_back(row_f2[i][0]);
        end
      endcase
    end
    drain_pipe();
    check_status(1'b1);
    close_test();

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errs);
    if (n_errs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== verification/adc_rx_input.dat ====
# c chan_enable offset_binary offset_a offset_b | d rx_data valid | w idle_cycles
# e out_data or_a or_b, all fields in hex, rx_data and out_data msb first
# both channels, byte unpack and interleave
c 3 0 0000 0000
d 00eeccaaffddbb998866442277553311 1
e ff007788ddee5566bbcc334499aa1122 0 0
d ffffffffffffffffffffffffffffffff 0
d 00ffff0001ff7f800403020100000000 1
e 01000004ffff00037fff000280000001 0 0
# channel a only, two beats per word
c 1 0 0000 0000
d 00eeccaaffddbb998866442277553311 1
w 2
d 00ffff0001ff7f800403020100000000 1
e 00040003000200017788556633441122 0 0
# left half held, dropped by the next enable change
d 00eeccaaffddbb998866442277553311 1
# channel b only
c 2 0 0000 0000
d 00ffff0001ff7f800403020100000000 1
d 00eeccaaffddbb998866442277553311 1
e ff00ddeebbcc99aa0100ffff7fff8000 0 0
# offset binary to two's complement
c 3 1 0000 0000
d 01010000008040c0ffff00007fff0080 1
e 8001ffff00017fffc000800040000000 0 0
# offsets with saturation, a clips high then b clips low
c 3 0 0100 ff00
d 00001000028100100000f000007fff10 1
e 0100010080007fffff1000f00f001100 1 0
d 00ffff00007f80800000000000000080 1
e ff0001007eff01008000010080008100 0 1
# over-range flag ors over both beats of a single channel word
c 1 0 0100 ff00
d 00001000028100100000f000007fff10 1
d 00ffff00007f80800000000000000080 1
e 010001000100810001007fff00f01100 1 0
# both channels off, no output
c 0 0 0000 0000
d 00eeccaaffddbb998866442277553311 1
# eight back to back beats, then beats with gaps
c 3 0 0000 0000
d 03020100212121210302010011111111 1
e 21031103210211022101110121001100 0 0
d 03020100222222220302010012121212 1
e 22031203220212022201120122001200 0 0
d 03020100232323230302010013131313 1
e 23031303230213022301130123001300 0 0
d 03020100242424240302010014141414 1
e 24031403240214022401140124001400 0 0
d 03020100252525250302010015151515 1
e 25031503250215022501150125001500 0 0
d 03020100262626260302010016161616 1
e 26031603260216022601160126001600 0 0
d 03020100272727270302010017171717 1
e 27031703270217022701170127001700 0 0
d 03020100282828280302010018181818 1
e 28031803280218022801180128001800 0 0
w 3
d 03020100292929290302010019191919 1
e 29031903290219022901190129001900 0 0
w 1
d 030201002a2a2a2a030201001a1a1a1a 1
e 2a031a032a021a022a011a012a001a00 0 0

// ==== project.f ====
+incdir+common
common/adc_rx_pkg.sv
hdl/adc_rx_if.sv
adc_channel/adc_channel.sv
adc_pack/adc_pack.sv
hdl/adc_rx_top.sv
verification/adc_rx_tb.sv
